/* rtl/cnn_buf_consts.svh */
`ifndef CNN_BUF_CONSTS_SVH
`define CNN_BUF_CONSTS_SVH

// Square image side, must be a multiple of 12
`define CNN_IMG_DIM        12

// Pixels packed into one load word
`define CNN_ROWS_PER_WORD  4

// Window geometry
`define CNN_WIN_ROWS       5
`define CNN_ROW_STRIDE     3

// Kernel fetch
`define CNN_KERNEL_WORDS   3
`define CNN_WEIGHT_DEPTH   64

`endif

/* rtl/cnn_buf_pkg.sv */
`include "cnn_buf_consts.svh"

package cnn_buf_pkg;

	typedef enum logic [1:0] {
		IDLE        = 2'd0,
		PARAM_LOAD  = 2'd1,
		IMAGE_LOAD  = 2'd2,
		START_ACCEL = 2'd3
	} buf_mode_t;

	typedef logic [7:0] pixel_t;

	typedef logic [23:0] weight_t;

	// Word 0 sits in the top bits
	typedef logic [`CNN_KERNEL_WORDS*24-1:0] kernel_t;

	// Three pixels, oldest column in the top byte
	typedef logic [23:0] lane_t;

	typedef lane_t [`CNN_WIN_ROWS-1:0] lanes_t;

endpackage

/* rtl/img_wr_if.sv */
`timescale 1ns/1ps
`include "cnn_buf_consts.svh"

interface img_wr_if import cnn_buf_pkg::*; ();
	localparam int GRP_W = $clog2(`CNN_IMG_DIM / `CNN_ROWS_PER_WORD);
	localparam int COL_W = $clog2(`CNN_IMG_DIM);

	logic                            we;
	logic [GRP_W-1:0]                row_group;
	logic [COL_W-1:0]                col;
	pixel_t [`CNN_ROWS_PER_WORD-1:0] word;

	modport loader (output we, row_group, col, word);
	modport bank   (input we, row_group, col, word);

endinterface

/* rtl/sram_1p.sv */
`timescale 1ns/1ps

module sram_1p #(
	parameter int  DEPTH = 64,
	parameter type T     = logic [7:0]
) (
	input  logic                     clk,
	input  logic                     i_en,
	input  logic                     i_we,
	input  logic [$clog2(DEPTH)-1:0] i_addr,
	input  T                         i_wdata,
	output T                         o_rdata
);

	T mem [DEPTH];

	// Write or registered read, never both
	always_ff @(posedge clk) begin
		if (i_en) begin
			if (i_we) begin
				mem[i_addr] <= i_wdata;
			end else begin
				o_rdata <= mem[i_addr];
			end
		end
	end

endmodule

/* rtl/stream_loader.sv */
`timescale 1ns/1ps
`include "cnn_buf_consts.svh"

module stream_loader import cnn_buf_pkg::*; (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  buf_mode_t                            i_state,
	input  logic [31:0]                          i_s_tdata,
	input  logic                                 i_s_tvalid,
	input  logic                                 i_s_tlast,
	output logic                                 o_s_tready,
	output logic                                 o_state_cnvt,
	output logic                                 o_w_we,
	output logic [$clog2(`CNN_WEIGHT_DEPTH)-1:0] o_w_addr,
	output weight_t                              o_w_data,
	img_wr_if.loader                             wr
);
	localparam int GRP_W  = $clog2(`CNN_IMG_DIM / `CNN_ROWS_PER_WORD);
	localparam int COL_W  = $clog2(`CNN_IMG_DIM);
	localparam int ADDR_W = $clog2(`CNN_WEIGHT_DEPTH);

	logic              accept;
	logic [ADDR_W-1:0] w_addr_q;
	logic [GRP_W-1:0]  grp_q;
	logic [COL_W-1:0]  col_q;

	////////////////////////////////////////
	// Stream handshake
	assign o_s_tready   = (i_state == PARAM_LOAD) || (i_state == IMAGE_LOAD);
	assign accept       = i_s_tvalid && o_s_tready;
	assign o_state_cnvt = accept && i_s_tlast;

	// Weight write, low 24 bits
	assign o_w_we   = accept && (i_state == PARAM_LOAD);
	assign o_w_addr = w_addr_q;
	assign o_w_data = i_s_tdata[23:0];

	// Image write, byte b lands in row 4g+b
	assign wr.we        = accept && (i_state == IMAGE_LOAD);
	assign wr.row_group = grp_q;
	assign wr.col       = col_q;
	assign wr.word      = i_s_tdata;

	////////////////////////////////////////
	// Address counters
	always_ff @(posedge clk) begin
		if (!rstn || i_state == IDLE) begin
			w_addr_q <= '0;
			grp_q    <= '0;
			col_q    <= '0;
		end else if (o_w_we) begin
			w_addr_q <= w_addr_q + 1'b1;
		end else if (wr.we) begin
			if (col_q == COL_W'(`CNN_IMG_DIM - 1)) begin
				col_q <= '0;
				grp_q <= grp_q + 1'b1;
			end else begin
				col_q <= col_q + 1'b1;
			end
		end
	end

endmodule

/* rtl/image_bank.sv */
`timescale 1ns/1ps
`include "cnn_buf_consts.svh"

module image_bank import cnn_buf_pkg::*; (
	input  logic                            clk,
	input  logic                            i_rd_en,
	input  logic [$clog2(`CNN_IMG_DIM)-1:0] i_rd_col,
	output pixel_t [`CNN_IMG_DIM-1:0]       o_col_px,
	img_wr_if.bank                          wr
);
	localparam int GRP_W = $clog2(`CNN_IMG_DIM / `CNN_ROWS_PER_WORD);
	localparam int COL_W = $clog2(`CNN_IMG_DIM);

	// One RAM per image row, indexed by column
	for (genvar r = 0; r < `CNN_IMG_DIM; r++) begin : g_row
		logic             row_we;
		logic [COL_W-1:0] row_addr;

		// Row r belongs to group r/4
		assign row_we   = wr.we && (wr.row_group == GRP_W'(r / `CNN_ROWS_PER_WORD));
		assign row_addr = row_we ? wr.col : i_rd_col;

		sram_1p #(
			.DEPTH (`CNN_IMG_DIM),
			.T     (pixel_t)
		) ram_inst (
			.clk     (clk),
			.i_en    (row_we || i_rd_en),
			.i_we    (row_we),
			.i_addr  (row_addr),
			.i_wdata (wr.word[r % `CNN_ROWS_PER_WORD]),
			.o_rdata (o_col_px[r])
		);
	end

endmodule

/* rtl/kernel_store.sv */
`timescale 1ns/1ps
`include "cnn_buf_consts.svh"

module kernel_store import cnn_buf_pkg::*; (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  buf_mode_t                            i_state,
	input  logic                                 i_w_we,
	input  logic [$clog2(`CNN_WEIGHT_DEPTH)-1:0] i_w_addr,
	input  weight_t                              i_w_data,
	output kernel_t                              o_wdata,
	output logic                                 o_wdata_valid
);
	localparam int ADDR_W  = $clog2(`CNN_WEIGHT_DEPTH);
	localparam int FETCH_W = $clog2(`CNN_KERNEL_WORDS + 1);
	localparam int KEEP_W  = $bits(kernel_t) - $bits(weight_t);

	logic               accel;
	logic               rd_en;
	logic [FETCH_W-1:0] fetch_q;
	logic               rd_q;
	logic               last_q;
	logic               full_q;
	logic [ADDR_W-1:0]  ram_addr;
	weight_t            rd_data;
	kernel_t            shift_q;

	assign accel    = (i_state == START_ACCEL);
	assign rd_en    = accel && (fetch_q != FETCH_W'(`CNN_KERNEL_WORDS));
	assign ram_addr = accel ? ADDR_W'(fetch_q) : i_w_addr;

	sram_1p #(
		.DEPTH (`CNN_WEIGHT_DEPTH),
		.T     (weight_t)
	) weight_ram_inst (
		.clk     (clk),
		.i_en    (i_w_we || rd_en),
		.i_we    (i_w_we),
		.i_addr  (ram_addr),
		.i_wdata (i_w_data),
		.o_rdata (rd_data)
	);

	// Fetch runs once per stay in START_ACCEL
	always_ff @(posedge clk) begin
		if (!rstn || !accel) begin
			fetch_q       <= '0;
			rd_q          <= 1'b0;
			last_q        <= 1'b0;
			full_q        <= 1'b0;
			o_wdata_valid <= 1'b0;
		end else begin
			if (rd_en) begin
				fetch_q <= fetch_q + 1'b1;
			end
			rd_q          <= rd_en;
			last_q        <= rd_en && (fetch_q == FETCH_W'(`CNN_KERNEL_WORDS - 1));
			full_q        <= last_q;
			o_wdata_valid <= full_q;
		end
	end

	// Word 0 ends up in the top bits
	always_ff @(posedge clk) begin
		if (rd_q) begin
			shift_q <= {shift_q[KEEP_W-1:0], rd_data};
		end
		if (full_q) begin
			o_wdata <= shift_q;
		end
	end

endmodule

/* rtl/window_streamer.sv */
`timescale 1ns/1ps
`include "cnn_buf_consts.svh"

module window_streamer import cnn_buf_pkg::*; (
	input  logic                            clk,
	input  logic                            rstn,
	input  buf_mode_t                       i_state,
	input  pixel_t [`CNN_IMG_DIM-1:0]       i_col_px,
	output logic                            o_rd_en,
	output logic [$clog2(`CNN_IMG_DIM)-1:0] o_rd_col,
	output lanes_t                          o_pdata,
	output logic                            o_pdata_valid
);
	localparam int DIM    = `CNN_IMG_DIM;
	localparam int NWIN   = DIM / `CNN_ROW_STRIDE;
	localparam int STEP_W = $clog2(DIM + 2);
	localparam int WIN_W  = $clog2(NWIN + 1);
	localparam int COL_W  = $clog2(DIM);
	localparam int KEEP_W = $bits(lane_t) - $bits(pixel_t);

	logic                       accel;
	logic                       active;
	logic                       data_step;
	logic [STEP_W-1:0]          step_q;
	logic [WIN_W-1:0]           win_q;
	logic                       s1_vld;
	logic                       s1_pad;
	logic                       s1_beat;
	logic [WIN_W-1:0]           s1_win;
	pixel_t [`CNN_WIN_ROWS-1:0] sel_px;

	assign accel  = (i_state == START_ACCEL);
	assign active = accel && (win_q != WIN_W'(NWIN));

	// Step 0 and step DIM+1 are the zero pad columns
	assign data_step = (step_q != '0) && (step_q <= STEP_W'(DIM));
	assign o_rd_en   = active && data_step;
	assign o_rd_col  = COL_W'(step_q - 1'b1);

	////////////////////////////////////////
	// Step and window sequencing
	always_ff @(posedge clk) begin
		if (!rstn || !accel) begin
			step_q <= '0;
			win_q  <= '0;
		end else if (active) begin
			if (step_q == STEP_W'(DIM + 1)) begin
				step_q <= '0;
				win_q  <= win_q + 1'b1;
			end else begin
				step_q <= step_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			s1_vld <= 1'b0;
		end else begin
			s1_vld <= active;
		end
	end

	// Tags that travel alongside the RAM read
	always_ff @(posedge clk) begin
		s1_pad  <= !data_step;
		s1_beat <= (step_q >= STEP_W'(2));
		s1_win  <= win_q;
	end

	////////////////////////////////////////
	// Row select, window w starts at row 3w-1
	always_comb begin
		int row;
		for (int j = 0; j < `CNN_WIN_ROWS; j++) begin
			row = `CNN_ROW_STRIDE * int'(s1_win) - 1 + j;
			if (s1_pad || row < 0 || row >= DIM) begin
				sel_px[j] = '0;
			end else begin
				sel_px[j] = i_col_px[row];
			end
		end
	end

	// Newest column enters at the bottom byte
	always_ff @(posedge clk) begin
		if (s1_vld) begin
			for (int j = 0; j < `CNN_WIN_ROWS; j++) begin
				o_pdata[j] <= {o_pdata[j][KEEP_W-1:0], sel_px[j]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_pdata_valid <= 1'b0;
		end else begin
			o_pdata_valid <= s1_vld && s1_beat;
		end
	end

endmodule

/* rtl/cnn_in_buffer.sv */
`timescale 1ns/1ps
`include "cnn_buf_consts.svh"

module cnn_in_buffer import cnn_buf_pkg::*; (
	input  logic        clk,
	input  logic        rstn,
	input  logic [31:0] i_s_tdata,
	input  logic        i_s_tvalid,
	input  logic        i_s_tlast,
	output logic        o_s_tready,
	input  buf_mode_t   i_state,
	output logic        o_state_cnvt,
	output kernel_t     o_wdata,
	output logic        o_wdata_valid,
	output lanes_t      o_pdata,
	output logic        o_pdata_valid
);

	logic                                 w_we;
	logic [$clog2(`CNN_WEIGHT_DEPTH)-1:0] w_addr;
	weight_t                              w_data;
	logic                                 rd_en;
	logic [$clog2(`CNN_IMG_DIM)-1:0]      rd_col;
	pixel_t [`CNN_IMG_DIM-1:0]            col_px;

	img_wr_if img_wr ();

	////////////////////////////////////////
	// Load path
	stream_loader stream_loader_inst (
		.clk          (clk),
		.rstn         (rstn),
		.i_state      (i_state),
		.i_s_tdata    (i_s_tdata),
		.i_s_tvalid   (i_s_tvalid),
		.i_s_tlast    (i_s_tlast),
		.o_s_tready   (o_s_tready),
		.o_state_cnvt (o_state_cnvt),
		.o_w_we       (w_we),
		.o_w_addr     (w_addr),
		.o_w_data     (w_data),
		.wr           (img_wr.loader)
	);

	image_bank image_bank_inst (
		.clk      (clk),
		.i_rd_en  (rd_en),
		.i_rd_col (rd_col),
		.o_col_px (col_px),
		.wr       (img_wr.bank)
	);

	////////////////////////////////////////
	// Accelerator side
	kernel_store kernel_store_inst (
		.clk           (clk),
		.rstn          (rstn),
		.i_state       (i_state),
		.i_w_we        (w_we),
		.i_w_addr      (w_addr),
		.i_w_data      (w_data),
		.o_wdata       (o_wdata),
		.o_wdata_valid (o_wdata_valid)
	);

	window_streamer window_streamer_inst (
		.clk           (clk),
		.rstn          (rstn),
		.i_state       (i_state),
		.i_col_px      (col_px),
		.o_rd_en       (rd_en),
		.o_rd_col      (rd_col),
		.o_pdata       (o_pdata),
		.o_pdata_valid (o_pdata_valid)
	);

endmodule

/* tb/cnn_in_buffer_asserts.sv */
`timescale 1ns/1ps

module cnn_in_buffer_asserts import cnn_buf_pkg::*; (
	input logic      clk,
	input logic      rstn,
	input buf_mode_t i_state,
	input logic      o_s_tready,
	input logic      o_wdata_valid,
	input logic      o_pdata_valid
);

	// Count of failed assertions
	int fail_count = 0;

	a_ready_mode: assert property (@(posedge clk) disable iff (!rstn)
		o_s_tready == (i_state == PARAM_LOAD || i_state == IMAGE_LOAD))
	else begin
		fail_count++;
		$error("o_s_tready does not follow the load modes");
	end

	a_kernel_pulse: assert property (@(posedge clk) disable iff (!rstn)
		o_wdata_valid |=> !o_wdata_valid)
	else begin
		fail_count++;
		$error("o_wdata_valid high on two consecutive cycles");
	end

	// Pipeline drains within three cycles of leaving START_ACCEL
	a_pdata_quiet: assert property (@(posedge clk) disable iff (!rstn)
		(i_state != START_ACCEL) [*3] |-> !o_pdata_valid)
	else begin
		fail_count++;
		$error("o_pdata_valid high outside START_ACCEL");
	end

endmodule

bind cnn_in_buffer cnn_in_buffer_asserts asserts_inst (.*);

/* tb/cnn_in_buffer_tb.sv */
`timescale 1ns/1ps
`include "cnn_buf_consts.svh"

module cnn_in_buffer_tb import cnn_buf_pkg::*; ();
	localparam int DIM          = `CNN_IMG_DIM;
	localparam int N_WEIGHTS    = 6;
	localparam int IMG_WORDS    = DIM * DIM / `CNN_ROWS_PER_WORD;
	localparam int STREAM_BEATS = DIM * (DIM / `CNN_ROW_STRIDE);
	localparam int RESET_CYCLES = 10;
	// A word with its widest gap takes three cycles
	localparam int LOAD_CYCLES   = 3 * (N_WEIGHTS + IMG_WORDS);
	localparam int STREAM_CYCLES = (DIM / `CNN_ROW_STRIDE) * (DIM + 6);
	localparam int TIMEOUT = 2 * (RESET_CYCLES + LOAD_CYCLES + 2 * STREAM_CYCLES + 200);

	logic        clk = 1'b0;
	logic        rstn;
	logic [31:0] i_s_tdata;
	logic        i_s_tvalid;
	logic        i_s_tlast;
	logic        o_s_tready;
	buf_mode_t   i_state;
	logic        o_state_cnvt;
	kernel_t     o_wdata;
	logic        o_wdata_valid;
	lanes_t      o_pdata;
	logic        o_pdata_valid;

	int      seed = 44;
	int      cycles = 0;
	int      kernel_pulses = 0;
	kernel_t kernel_seen;
	lanes_t  beats [$];
	weight_t ref_w [N_WEIGHTS];
	pixel_t  ref_px [DIM][DIM];

	cnn_in_buffer cnn_in_buffer_inst (.*);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// Output monitors and run limit
	always @(negedge clk) begin
		if (rstn && o_pdata_valid) begin
			beats.push_back(o_pdata);
		end
		if (rstn && o_wdata_valid) begin
			kernel_pulses++;
			kernel_seen = o_wdata;
		end
	end

	always @(negedge clk) begin
		cycles++;
		if (cnn_in_buffer_inst.asserts_inst.fail_count != 0) begin
			$display("A bound assertion on the DUT ports failed");
			fail_run();
		end else if (cycles > TIMEOUT) begin
			$display("Timeout after %0d cycles waiting for the DUT", cycles);
			fail_run();
		end
	end

	////////////////////////////////////////
	// Compare tasks
	task automatic fail_run();
		$display("CHECKS FAILED");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic check_kernel(input string name, input kernel_t exp, input kernel_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_lanes(input string name, input lanes_t exp, input lanes_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %b actual %b", name, exp, act);
			fail_run();
		end
	endtask

	////////////////////////////////////////
	// Reference model
	function automatic pixel_t ref_pixel(input int r, input int c);
		if (r < 0 || r >= DIM || c < 0 || c >= DIM) begin
			return '0;
		end
		return ref_px[r][c];
	endfunction

	// Oldest column k-1 lands in the top byte
	function automatic lanes_t expected_lanes(input int w, input int k);
		lanes_t lanes;
		int     row;
		for (int j = 0; j < `CNN_WIN_ROWS; j++) begin
			row = `CNN_ROW_STRIDE * w - 1 + j;
			lanes[j] = {ref_pixel(row, k - 1), ref_pixel(row, k), ref_pixel(row, k + 1)};
		end
		return lanes;
	endfunction

	////////////////////////////////////////
	// Stimulus helpers
	task automatic set_mode(input buf_mode_t mode);
		@(posedge clk);
		i_state    <= mode;
		i_s_tvalid <= 1'b0;
		i_s_tlast  <= 1'b0;
	endtask

	// Beat is accepted on the edge after the checks
	task automatic send_word(input logic [31:0] data, input logic last, input int gap,
		input string name);
		repeat (gap) begin
			@(posedge clk);
			i_s_tvalid <= 1'b0;
			// tlast alone must not convert
			i_s_tlast  <= 1'b1;
			@(negedge clk);
			check_bit({name, " gap cnvt"}, 1'b0, o_state_cnvt);
		end
		@(posedge clk);
		i_s_tdata  <= data;
		i_s_tvalid <= 1'b1;
		i_s_tlast  <= last;
		@(negedge clk);
		check_bit({name, " tready"}, 1'b1, o_s_tready);
		check_bit({name, " cnvt"}, last, o_state_cnvt);
	endtask

	////////////////////////////////////////
	// Directed tests
	task automatic test_reset_idle();
		@(negedge clk);
		check_bit("test_reset_idle wdata_valid", 1'b0, o_wdata_valid);
		check_bit("test_reset_idle pdata_valid", 1'b0, o_pdata_valid);
		check_bit("test_reset_idle cnvt", 1'b0, o_state_cnvt);
		check_bit("test_reset_idle tready", 1'b0, o_s_tready);
	endtask

	task automatic test_param_load();
		logic [31:0] data;
		set_mode(PARAM_LOAD);
		for (int k = 0; k < N_WEIGHTS; k++) begin
			data = $random(seed);
			ref_w[k] = data[23:0];
			send_word(data, k == N_WEIGHTS - 1, {$random(seed)} % 3, "test_param_load");
		end
		set_mode(IDLE);
		// No beat may be taken outside the load modes
		@(posedge clk);
		i_s_tvalid <= 1'b1;
		i_s_tlast  <= 1'b1;
		@(negedge clk);
		check_bit("test_param_load idle tready", 1'b0, o_s_tready);
		check_bit("test_param_load idle cnvt", 1'b0, o_state_cnvt);
		set_mode(IDLE);
	endtask

	task automatic test_image_load();
		logic [31:0] data;
		int          g;
		int          c;
		set_mode(IMAGE_LOAD);
		for (int n = 0; n < IMG_WORDS; n++) begin
			data = $random(seed);
			g = n / DIM;
			c = n % DIM;
			for (int b = 0; b < `CNN_ROWS_PER_WORD; b++) begin
				ref_px[`CNN_ROWS_PER_WORD * g + b][c] = data[8 * b +: 8];
			end
			send_word(data, n == IMG_WORDS - 1, {$random(seed)} % 2, "test_image_load");
		end
		set_mode(IDLE);
	endtask

	task automatic test_kernel_fetch();
		set_mode(START_ACCEL);
		while (kernel_pulses == 0) begin
			@(posedge clk);
		end
		check_kernel("test_kernel_fetch", {ref_w[0], ref_w[1], ref_w[2]}, kernel_seen);
		repeat (`CNN_KERNEL_WORDS + 4) @(posedge clk);
		check_bit("test_kernel_fetch single pulse", 1'b1, kernel_pulses == 1);
	endtask

	task automatic test_window_stream();
		while (beats.size() < STREAM_BEATS) begin
			@(posedge clk);
		end
		repeat (DIM + 6) @(posedge clk);
		if (beats.size() != STREAM_BEATS) begin
			$display("CHECK FAILED test_window_stream beat count expected %0d actual %0d",
				STREAM_BEATS, beats.size());
			fail_run();
		end
		for (int w = 0; w < DIM / `CNN_ROW_STRIDE; w++) begin
			for (int k = 0; k < DIM; k++) begin
				check_lanes($sformatf("test_window_stream w%0d k%0d", w, k),
					expected_lanes(w, k), beats[w * DIM + k]);
			end
		end
	endtask

	task automatic test_restart();
		set_mode(IDLE);
		// Let beats still in flight drain
		repeat (3) @(posedge clk);
		beats.delete();
		kernel_pulses = 0;
		set_mode(START_ACCEL);
		while (kernel_pulses == 0) begin
			@(posedge clk);
		end
		check_kernel("test_restart", {ref_w[0], ref_w[1], ref_w[2]}, kernel_seen);
		while (beats.size() == 0) begin
			@(posedge clk);
		end
		check_lanes("test_restart first beat", expected_lanes(0, 0), beats[0]);
		set_mode(IDLE);
	endtask

	initial begin
		rstn       = 1'b0;
		i_state    = IDLE;
		i_s_tdata  = '0;
		i_s_tvalid = 1'b0;
		i_s_tlast  = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstn <= 1'b1;
		test_reset_idle();
		test_param_load();
		test_image_load();
		test_kernel_fetch();
		test_window_stream();
		test_restart();
		@(negedge clk);
		if (cnn_in_buffer_inst.asserts_inst.fail_count != 0) begin
			$display("A bound assertion on the DUT ports failed");
			fail_run();
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

/* vlog.f */
+incdir+rtl
rtl/cnn_buf_pkg.sv
rtl/img_wr_if.sv
rtl/sram_1p.sv
rtl/stream_loader.sv
rtl/image_bank.sv
rtl/kernel_store.sv
rtl/window_streamer.sv
rtl/cnn_in_buffer.sv
tb/cnn_in_buffer_asserts.sv
tb/cnn_in_buffer_tb.sv

/* Bender.yml */
package:
  name: cnn_in_buffer

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cnn_buf_pkg.sv
      - rtl/img_wr_if.sv
      - rtl/sram_1p.sv
      - rtl/stream_loader.sv
      - rtl/image_bank.sv
      - rtl/kernel_store.sv
      - rtl/window_streamer.sv
      - rtl/cnn_in_buffer.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/cnn_in_buffer_asserts.sv
      - tb/cnn_in_buffer_tb.sv
